// ==== list.f ====
+incdir+.
usiPkg.sv
usiBusIf.sv
usiFabric.sv
usiGpioCsr.sv
usiPwmCsr.sv
usiSubsystem.sv
tbUsiSubsystem.sv

// ==== Makefile ====
# Verilator build for the USI subsystem testbench

VERILATOR  ?= verilator
TOP        := tbUsiSubsystem
RTL_TOP    := usiSubsystem
FILELIST   := list.f
LINT_FLAGS := --lint-only -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell sed -n '/\.sv$$/p' $(FILELIST)) usi_config.svh
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '>>> PASS' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tbUsiSubsystem.sv ====
// Self-checking testbench for the USI subsystem, drives the master port and checks reads and pins
`timescale 1ns/1ps
`include "usi_config.svh"

module tbUsiSubsystem;

	localparam int ClkPeriod = 20;                   // ns
	// Cycle budget per test, in test order
	localparam int RunCycles = 10 + 60 + 50 + 20 + 220 + 50 + 50;
	localparam int MarginCycles = 200;

	//--------------------------------------------------
	// DUT signals
	//--------------------------------------------------
	logic iUsiClk = 1'b0;
	logic rstN = 1'b0;
	logic [`USI_DATA_BITS-1:0] mAdrs = '0;
	logic [`USI_DATA_BITS-1:0] mWd = '0;
	logic mWCke = 1'b0;
	logic [`USI_GPIO_WIDTH-1:0] gpioIn = '0;
	logic [`USI_DATA_BITS-1:0] mRd;
	logic mVd;
	logic [`USI_GPIO_WIDTH-1:0] gpioOut;
	logic [`USI_GPIO_WIDTH-1:0] gpioOe;
	logic pwmOut;

	usiSubsystem u_dut
	(
		.iUsiClk (iUsiClk),
		.rstN    (rstN),
		.mAdrs   (mAdrs),
		.mWd     (mWd),
		.mWCke   (mWCke),
		.mRd     (mRd),
		.mVd     (mVd),
		.gpioIn  (gpioIn),
		.gpioOut (gpioOut),
		.gpioOe  (gpioOe),
		.pwmOut  (pwmOut)
	);

	always #(ClkPeriod / 2) iUsiClk = ~iUsiClk;

	//--------------------------------------------------
	// Bookkeeping
	//--------------------------------------------------
	logic [`USI_DATA_BITS-1:0] expQ [$];             // Expected read data, issue order
	logic [31:0] lcgState = 32'd63642;
	int failCnt = 0;
	int testCnt = 0;
	int passCnt = 0;
	int failAtStart = 0;
	logic [2:0] rdHist = '0;                         // Read strobes of the last 3 edges
	logic rdStrobe;

	assign rdStrobe = mWCke && (mAdrs[31:30] == `USI_CMD_READ);

	always @(posedge iUsiClk)
		rdHist <= {rdHist[1:0], rdStrobe};

	// Every read answered exactly three cycles later, nothing else answered
	assert property (@(posedge iUsiClk) disable iff (!rstN) mVd == rdHist[2])
	else
	begin
		failCnt++;
		$display("Fail at %0t: mVd is %0b, expected %0b", $time, $sampled(mVd),
			$sampled(rdHist[2]));
	end

	// Read data against the oldest outstanding read
	always @(posedge iUsiClk)
	begin
		if (rstN && mVd)
		begin
			if (expQ.size() == 0)
			begin
				failCnt++;
				$display("Read data returned at %0t with no read outstanding", $time);
			end
			else
			begin
				assert (mRd == expQ[0])
				else
				begin
					failCnt++;
					$display("Fail at %0t: mRd is %h, expected %h", $time, mRd, expQ[0]);
				end
				void'(expQ.pop_front());
			end
		end
	end

	//--------------------------------------------------
	// Helpers
	//--------------------------------------------------
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp)
		else
		begin
			failCnt++;
			$display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// One command strobe, left high for the caller to clear
	task automatic issueCmd(input logic [1:0] cmd, input logic [7:0] blk,
		input logic [15:0] csr, input logic [31:0] data);
		@(posedge iUsiClk);
		mAdrs <= {cmd, 6'b0, blk, csr};              // Field layout of the address word
		mWd   <= data;
		mWCke <= 1'b1;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(posedge iUsiClk);
			mWCke <= 1'b0;
		end
	endtask

	task automatic writeCsr(input logic [7:0] blk, input logic [15:0] csr, input logic [31:0] data);
		issueCmd(`USI_CMD_WRITE, blk, csr, data);
		idle(1);
	endtask

	// Pipelined read, no wait
	task automatic readExpect(input logic [7:0] blk, input logic [15:0] csr, input logic [31:0] exp);
		issueCmd(`USI_CMD_READ, blk, csr, '0);
		expQ.push_back(exp);
	endtask

	// Waits for every outstanding read, gives up after 10 cycles
	task automatic drainReads();
		int waited;
		waited = 0;
		idle(1);
		while (expQ.size() != 0 && waited < 10)
		begin
			@(posedge iUsiClk);
			waited++;
		end
		if (expQ.size() != 0)
		begin
			failCnt++;
			$display("%0d reads never returned data, at %0t", expQ.size(), $time);
			expQ.delete();
		end
	endtask

	task automatic readCheck(input logic [7:0] blk, input logic [15:0] csr, input logic [31:0] exp);
		readExpect(blk, csr, exp);
		drainReads();
	endtask

	task automatic startTest();
		failAtStart = failCnt;
	endtask

	task automatic endTest(input string name);
		testCnt++;
		if (failCnt == failAtStart)
		begin
			passCnt++;
			$display("Test %0d %s: passed", testCnt, name);
		end
		else
			$display("Test %0d %s: failed", testCnt, name);
	endtask

	// Counts pwmOut highs in every window of one period over three periods
	task automatic checkPwmWindows(input int period, input int duty);
		logic seen [0:63];
		int highs;
		int s;
		int k;
		for (s = 0; s < 3 * period; s++)
		begin
			@(posedge iUsiClk);
			seen[s] = pwmOut;
		end
		for (s = 0; s + period <= 3 * period; s++)
		begin
			highs = 0;
			for (k = 0; k < period; k++)
				highs += seen[s + k];
			expectEq("pwmOut high count", highs, duty);
		end
	endtask

	//--------------------------------------------------
	// Watchdog
	//--------------------------------------------------
	initial
	begin
		#(ClkPeriod * (RunCycles + MarginCycles));
		$display("Watchdog expired, the run did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

	//--------------------------------------------------
	// Test sequence
	//--------------------------------------------------
	logic [7:0] gpioData;
	logic [7:0] gpioDir;
	logic [7:0] inVal;
	int pwmPeriod;
	int pwmDuty;
	int lowCnt;

	initial
	begin
		repeat (2) @(posedge iUsiClk);
		rstN <= 1'b1;

		// Reset values
		startTest();
		@(posedge iUsiClk);
		expectEq("mVd", mVd, 0);
		expectEq("gpioOut", gpioOut, 0);
		expectEq("gpioOe", gpioOe, 0);
		expectEq("pwmOut", pwmOut, 0);
		for (int c = 0; c < 4; c++)
		begin
			readCheck(`USI_BLK_GPIO, c, 0);
			readCheck(`USI_BLK_PWM, c, 0);
		end
		endTest("reset values");

		// GPIO data and direction
		startTest();
		gpioData = nextRand() >> 24;
		gpioDir  = nextRand() >> 24;
		writeCsr(`USI_BLK_GPIO, 0, gpioData);
		writeCsr(`USI_BLK_GPIO, 1, gpioDir);
		idle(2);
		expectEq("gpioOe", gpioOe, gpioDir);
		expectEq("gpioOut", gpioOut, gpioData & gpioDir);   // Undriven pins low
		readCheck(`USI_BLK_GPIO, 0, gpioData);
		readCheck(`USI_BLK_GPIO, 1, gpioDir);
		writeCsr(`USI_BLK_GPIO, 2, 32'hFF);                  // Read only
		idle(2);
		readCheck(`USI_BLK_GPIO, 2, 0);
		endTest("gpio registers");

		// Input readback through the synchronizer
		startTest();
		inVal = nextRand() >> 24;
		@(posedge iUsiClk);
		gpioIn <= inVal;
		idle(4);
		readCheck(`USI_BLK_GPIO, 2, inVal);
		endTest("gpio input");

		// PWM windows, then disabled
		startTest();
		pwmPeriod = 4 + (nextRand() >> 24) % 13;
		pwmDuty   = (nextRand() >> 24) % (pwmPeriod + 1);
		writeCsr(`USI_BLK_PWM, 0, pwmPeriod);
		writeCsr(`USI_BLK_PWM, 1, pwmDuty);
		writeCsr(`USI_BLK_PWM, 2, 1);
		idle(3);
		checkPwmWindows(pwmPeriod, pwmDuty);
		readCheck(`USI_BLK_PWM, 2, 1);
		writeCsr(`USI_BLK_PWM, 2, 0);
		idle(2);
		lowCnt = 0;
		repeat (2 * pwmPeriod)
		begin
			@(posedge iUsiClk);
			lowCnt += !pwmOut;
		end
		expectEq("pwmOut low count", lowCnt, 2 * pwmPeriod);
		readCheck(`USI_BLK_PWM, 0, pwmPeriod);
		readCheck(`USI_BLK_PWM, 1, pwmDuty);
		endTest("pwm output");

		// Unmapped blocks and back to back mixed reads
		startTest();
		readCheck(8'd0, 0, `USI_UNMAPPED_DATA);
		readCheck(8'd3, 1, `USI_UNMAPPED_DATA);
		readCheck(8'hFF, 2, `USI_UNMAPPED_DATA);
		readExpect(`USI_BLK_GPIO, 0, gpioData);
		readExpect(`USI_BLK_PWM, 0, pwmPeriod);
		readExpect(8'd0, 0, `USI_UNMAPPED_DATA);
		readExpect(`USI_BLK_GPIO, 1, gpioDir);
		readExpect(8'h55, 7, `USI_UNMAPPED_DATA);
		readExpect(`USI_BLK_PWM, 1, pwmDuty);
		readExpect(`USI_BLK_GPIO, 2, inVal);
		drainReads();
		endTest("unmapped and pipelined reads");

		// Commands 0 and 3 are no-ops
		startTest();
		issueCmd(2'd0, `USI_BLK_GPIO, 0, ~gpioData);
		issueCmd(2'd3, `USI_BLK_GPIO, 1, ~gpioDir);
		issueCmd(2'd0, `USI_BLK_PWM, 0, 16'hFFFF);
		issueCmd(2'd3, `USI_BLK_PWM, 2, 1);
		idle(4);
		expectEq("gpioOe", gpioOe, gpioDir);
		expectEq("pwmOut", pwmOut, 0);
		readCheck(`USI_BLK_GPIO, 0, gpioData);
		readCheck(`USI_BLK_GPIO, 1, gpioDir);
		readCheck(`USI_BLK_PWM, 0, pwmPeriod);
		readCheck(`USI_BLK_PWM, 2, 0);
		endTest("ignored commands");

		idle(2);
		$display("Tests run %0d, passed %0d, failed %0d, check failures %0d",
			testCnt, passCnt, testCnt - passCnt, failCnt);
		if (failCnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== usiSubsystem.sv ====
// USI subsystem top: fabric plus GPIO and PWM slaves behind plain master and pin ports
`timescale 1ns/1ps
`include "usi_config.svh"

module usiSubsystem
(
	input  logic                       iUsiClk,
	input  logic                       rstN,
	// Master command port
	input  logic [`USI_DATA_BITS-1:0]  mAdrs,   // {cmd, gap, blk, csr}
	input  logic [`USI_DATA_BITS-1:0]  mWd,
	input  logic                       mWCke,
	// Master read port, three cycles after a read
	output logic [`USI_DATA_BITS-1:0]  mRd,
	output logic                       mVd,
	// GPIO pins
	input  logic [`USI_GPIO_WIDTH-1:0] gpioIn,
	output logic [`USI_GPIO_WIDTH-1:0] gpioOut,
	output logic [`USI_GPIO_WIDTH-1:0] gpioOe,
	// PWM pin
	output logic                       pwmOut
);

	//--------------------------------------------------
	// One bus link per slave
	//--------------------------------------------------
	usiBusIf gpioBus ();
	usiBusIf pwmBus ();

	// Fabric, single master side
	usiFabric uFabric
	(
		.iUsiClk (iUsiClk),
		.rstN    (rstN),
		.mAdrs   (mAdrs),
		.mWd     (mWd),
		.mWCke   (mWCke),
		.mRd     (mRd),
		.mVd     (mVd),
		.gpioBus (gpioBus.fabric),
		.pwmBus  (pwmBus.fabric)
	);

	//--------------------------------------------------
	// Slaves
	//--------------------------------------------------
	usiGpioCsr uGpio
	(
		.iUsiClk (iUsiClk),
		.rstN    (rstN),
		.gpioIn  (gpioIn),
		.gpioOut (gpioOut),
		.gpioOe  (gpioOe),
		.bus     (gpioBus.slave)
	);

	usiPwmCsr uPwm
	(
		.iUsiClk (iUsiClk),
		.rstN    (rstN),
		.pwmOut  (pwmOut),
		.bus     (pwmBus.slave)
	);

endmodule

// ==== usiPwmCsr.sv ====
// PWM slave on the USI bus: period, duty and enable CSRs driving one PWM pin
`timescale 1ns/1ps
`include "usi_config.svh"

module usiPwmCsr import usiPkg::*;
(
	input  logic   iUsiClk,
	input  logic   rstN,
	output logic   pwmOut,                     // High while counter below duty
	usiBusIf.slave bus
);

	localparam int PadBits = `USI_DATA_BITS - `USI_PWM_BITS;

	//--------------------------------------------------
	// Command decode
	//--------------------------------------------------
	logic hit;
	logic wrHit;
	logic rdHit;

	assign hit   = bus.wCke && (bus.adrs.f.blk == `USI_BLK_PWM);
	assign wrHit = hit && (bus.adrs.f.cmd == `USI_CMD_WRITE);
	assign rdHit = hit && (bus.adrs.f.cmd == `USI_CMD_READ);

	//--------------------------------------------------
	// CSRs
	//--------------------------------------------------
	logic [`USI_PWM_BITS-1:0] periodReg;       // csr 0, counts per cycle
	logic [`USI_PWM_BITS-1:0] dutyReg;         // csr 1, high counts
	logic enReg;                               // csr 2, bit 0

	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
		begin
			periodReg <= '0;
			dutyReg   <= '0;
			enReg     <= 1'b0;
		end
		else if (wrHit)
		begin
			case (bus.adrs.f.csr)
				16'd0: periodReg <= bus.wd[`USI_PWM_BITS-1:0];
				16'd1: dutyReg   <= bus.wd[`USI_PWM_BITS-1:0];
				16'd2: enReg     <= bus.wd[0];
				default: ;                     // Outside the map
			endcase
		end
	end

	//--------------------------------------------------
	// Period counter
	//--------------------------------------------------
	logic [`USI_PWM_BITS-1:0] cnt;
	logic [`USI_PWM_BITS:0] cntNext;           // One bit wider, no overflow

	assign cntNext = {1'b0, cnt} + 1'b1;

	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
			cnt <= '0;
		else if (!enReg)
			cnt <= '0;                         // Held at zero while off
		else if (cntNext >= {1'b0, periodReg})
			cnt <= '0;                         // Wrap at period minus one
		else
			cnt <= cntNext[`USI_PWM_BITS-1:0];
	end

	// Duty at or above period keeps the pin high
	assign pwmOut = enReg && (cnt < dutyReg);

	//--------------------------------------------------
	// Read return
	//--------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
			bus.vd <= 1'b0;
		else
			bus.vd <= rdHit;
	end

	always_ff @(posedge iUsiClk)
	begin
		if (rdHit)
		begin
			case (bus.adrs.f.csr)
				16'd0:   bus.rd <= {{PadBits{1'b0}}, periodReg};
				16'd1:   bus.rd <= {{PadBits{1'b0}}, dutyReg};
				16'd2:   bus.rd <= {{(`USI_DATA_BITS-1){1'b0}}, enReg};
				default: bus.rd <= '0;
			endcase
		end
	end

endmodule

// ==== usiGpioCsr.sv ====
// GPIO slave on the USI bus: output data, direction and synchronized input readback
`timescale 1ns/1ps
`include "usi_config.svh"

module usiGpioCsr import usiPkg::*;
(
	input  logic                       iUsiClk,
	input  logic                       rstN,
	// Pins
	input  logic [`USI_GPIO_WIDTH-1:0] gpioIn,  // Asynchronous inputs
	output logic [`USI_GPIO_WIDTH-1:0] gpioOut, // Masked output data
	output logic [`USI_GPIO_WIDTH-1:0] gpioOe,  // 1 drives the pin
	// Bus
	usiBusIf.slave                     bus
);

	localparam int PadBits = `USI_DATA_BITS - `USI_GPIO_WIDTH;

	//--------------------------------------------------
	// Command decode
	//--------------------------------------------------
	logic hit;                                 // Addressed to this block
	logic wrHit;
	logic rdHit;

	assign hit   = bus.wCke && (bus.adrs.f.blk == `USI_BLK_GPIO);
	assign wrHit = hit && (bus.adrs.f.cmd == `USI_CMD_WRITE);
	assign rdHit = hit && (bus.adrs.f.cmd == `USI_CMD_READ);

	//--------------------------------------------------
	// CSRs
	//--------------------------------------------------
	logic [`USI_GPIO_WIDTH-1:0] dataReg;       // csr 0
	logic [`USI_GPIO_WIDTH-1:0] dirReg;        // csr 1

	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
		begin
			dataReg <= '0;
			dirReg  <= '0;
		end
		else if (wrHit)
		begin
			// csr 2 is read only, higher CSRs do not exist
			case (bus.adrs.f.csr)
				16'd0: dataReg <= bus.wd[`USI_GPIO_WIDTH-1:0];
				16'd1: dirReg  <= bus.wd[`USI_GPIO_WIDTH-1:0];
				default: ;
			endcase
		end
	end

	//--------------------------------------------------
	// Input synchronizer, csr 2
	//--------------------------------------------------
	logic [`USI_GPIO_WIDTH-1:0] inMeta;        // First flop, may go metastable
	logic [`USI_GPIO_WIDTH-1:0] inSync;        // Safe to read

	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
		begin
			inMeta <= '0;
			inSync <= '0;
		end
		else
		begin
			inMeta <= gpioIn;
			inSync <= inMeta;
		end
	end

	//--------------------------------------------------
	// Read return, one cycle after the command
	//--------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
			bus.vd <= 1'b0;
		else
			bus.vd <= rdHit;
	end

	always_ff @(posedge iUsiClk)
	begin
		if (rdHit)
		begin
			case (bus.adrs.f.csr)
				16'd0:   bus.rd <= {{PadBits{1'b0}}, dataReg};
				16'd1:   bus.rd <= {{PadBits{1'b0}}, dirReg};
				16'd2:   bus.rd <= {{PadBits{1'b0}}, inSync};
				default: bus.rd <= '0;         // Unused CSR space
			endcase
		end
	end

	// Pins only driven where direction says output
	assign gpioOe  = dirReg;
	assign gpioOut = dataReg & dirReg;

endmodule

// ==== usiFabric.sv ====
// USI bus fabric: registers master commands, broadcasts them and returns read data in order
`timescale 1ns/1ps
`include "usi_config.svh"

module usiFabric import usiPkg::*;
(
	input  logic                      iUsiClk,
	input  logic                      rstN,
	// Master command
	input  logic [`USI_DATA_BITS-1:0] mAdrs,   // Raw address word
	input  logic [`USI_DATA_BITS-1:0] mWd,     // Write data
	input  logic                      mWCke,   // Command strobe
	// Master read return
	output logic [`USI_DATA_BITS-1:0] mRd,
	output logic                      mVd,
	// Slave links
	usiBusIf.fabric                   gpioBus,
	usiBusIf.fabric                   pwmBus
);

	//--------------------------------------------------
	// Master side decode
	//--------------------------------------------------
	usiAdrsWord mCmd;                          // Field view of the master word
	logic mRead;                               // Read strobe this cycle

	assign mCmd.raw = mAdrs;
	assign mRead = mWCke && (mCmd.f.cmd == `USI_CMD_READ);

	//--------------------------------------------------
	// Command register, cycle N+1
	//--------------------------------------------------
	usiAdrsWord adrsQ;
	logic [`USI_DATA_BITS-1:0] wdQ;
	logic wCkeQ;

	// Payload, sampled every cycle
	always_ff @(posedge iUsiClk)
	begin
		adrsQ <= mCmd;
		wdQ   <= mWd;
	end

	// Strobe, cleared on reset
	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
			wCkeQ <= 1'b0;
		else
			wCkeQ <= mWCke;
	end

	// Same command seen by every slave
	assign gpioBus.adrs = adrsQ;
	assign gpioBus.wd   = wdQ;
	assign gpioBus.wCke = wCkeQ;
	assign pwmBus.adrs  = adrsQ;
	assign pwmBus.wd    = wdQ;
	assign pwmBus.wCke  = wCkeQ;

	//--------------------------------------------------
	// Read tag line, two stages
	//--------------------------------------------------
	// Stage 2 lines up with the slave vd in cycle N+2
	logic [`USI_BLK_BITS-1:0] tagBlk1;
	logic [`USI_BLK_BITS-1:0] tagBlk2;
	logic tagRd1;
	logic tagRd2;

	always_ff @(posedge iUsiClk)
	begin
		tagBlk1 <= mCmd.f.blk;                 // Block of the read
		tagBlk2 <= tagBlk1;
	end

	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
		begin
			tagRd1 <= 1'b0;
			tagRd2 <= 1'b0;
		end
		else
		begin
			tagRd1 <= mRead;
			tagRd2 <= tagRd1;
		end
	end

	//--------------------------------------------------
	// Read return, cycle N+3
	//--------------------------------------------------
	// Valid follows the addressed slave, unmapped blocks answer themselves
	always_ff @(posedge iUsiClk)
	begin
		if (!rstN)
			mVd <= 1'b0;
		else if (tagRd2)
		begin
			case (tagBlk2)
				`USI_BLK_GPIO: mVd <= gpioBus.vd;
				`USI_BLK_PWM:  mVd <= pwmBus.vd;
				default:       mVd <= 1'b1;    // Marker is always valid
			endcase
		end
		else
			mVd <= 1'b0;
	end

	// Data held between reads
	always_ff @(posedge iUsiClk)
	begin
		if (tagRd2)
		begin
			case (tagBlk2)
				`USI_BLK_GPIO: mRd <= gpioBus.rd;
				`USI_BLK_PWM:  mRd <= pwmBus.rd;
				default:       mRd <= `USI_UNMAPPED_DATA;
			endcase
		end
	end

endmodule

// ==== usiBusIf.sv ====
// USI bus link between the fabric and one slave, one instance per slave
`timescale 1ns/1ps
`include "usi_config.svh"

interface usiBusIf import usiPkg::*;
();

	//--------------------------------------------------
	// Fabric to slave, broadcast command
	//--------------------------------------------------
	usiAdrsWord adrs;                          // Cmd, block and CSR
	logic [`USI_DATA_BITS-1:0] wd;             // Write data
	logic wCke;                                // One-cycle command strobe

	//--------------------------------------------------
	// Slave to fabric, read return
	//--------------------------------------------------
	logic [`USI_DATA_BITS-1:0] rd;             // Read data, valid with vd
	logic vd;                                  // One pulse per read

	// Fabric side drives the command
	modport fabric
	(
		output adrs,
		output wd,
		output wCke,
		input  rd,
		input  vd
	);

	// Slave side answers reads
	modport slave
	(
		input  adrs,
		input  wd,
		input  wCke,
		output rd,
		output vd
	);

endinterface

// ==== usiPkg.sv ====
// Shared USI bus types, imported by the fabric, the slaves and the bus interface
`include "usi_config.svh"

package usiPkg;

	//--------------------------------------------------
	// Bus address word
	//--------------------------------------------------
	// Master and fabric move it as a raw word, slaves pick out the fields
	typedef union packed
	{
		logic [`USI_DATA_BITS-1:0] raw;      // Flat view
		struct packed
		{
			logic [`USI_CMD_BITS-1:0] cmd;   // 1 write, 2 read
			logic [`USI_DATA_BITS-`USI_CMD_BITS-`USI_BLK_BITS-`USI_CSR_BITS-1:0] gap;
			logic [`USI_BLK_BITS-1:0] blk;   // Target block
			logic [`USI_CSR_BITS-1:0] csr;   // Register inside the block
		} f;
	} usiAdrsWord;

endpackage

// ==== usi_config.svh ====
// Bus widths, command codes and block map of the USI bus, included by RTL and testbench
`ifndef USI_CONFIG_SVH
`define USI_CONFIG_SVH

//--------------------------------------------------
// Bus word layout
//--------------------------------------------------
`define USI_DATA_BITS      32            // Data and address word width
`define USI_CMD_BITS       2             // Command field, bits 31..30
`define USI_BLK_BITS       8             // Block field, bits 23..16
`define USI_CSR_BITS       16            // CSR field, bits 15..0

// Command codes, 0 and 3 are ignored
`define USI_CMD_WRITE      2'd1
`define USI_CMD_READ       2'd2

// Block map
`define USI_BLK_GPIO       8'd1
`define USI_BLK_PWM        8'd2
`define USI_UNMAPPED_DATA  32'h1234_5678 // Easy to spot on a bad decode

// Slave sizes
`define USI_GPIO_WIDTH     8             // GPIO pin count
`define USI_PWM_BITS       16            // Period, duty and counter width

`endif
